//--- exec_cluster.f
+incdir+hdl
hdl/riscv_isa_pkg.sv
hdl/cluster_pkg.sv
hdl/control_unit.sv
hdl/exec_lane.sv
hdl/issue_stage.sv
hdl/retire_stage.sv
hdl/exec_cluster.sv
dv/exec_cluster_assert.sv
dv/exec_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_cluster.f --top-module exec_cluster_tb

./obj_dir/Vexec_cluster_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- dv/exec_cluster_tb.sv
`include "cluster_macros.svh"

module exec_cluster_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cluster_pkg::*;

    localparam int L = `CLUSTER_LANES;
    localparam int TESTS = 6;
    localparam int MAX_BUNDLES = 18;     // branch test is the longest
    localparam int CYCLES_PER_BUNDLE = 5;
    localparam int WATCHDOG_NS = (3 + 4 + TESTS * MAX_BUNDLES * CYCLES_PER_BUNDLE) * 20;

    logic           clk;
    logic           arst_n;
    issue_bundle_t  issue;
    retire_bundle_t retire;

    exec_cluster UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .retire (retire)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the directed tests did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic slot_t mk(logic [31:0] ins, logic [31:0] pc, logic [31:0] a,
                                 logic [31:0] b);
        slot_t s;
        s = {1'b1, ins, pc, a, b};
        return s;
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected lane result straight from the RV32I encoding
    function automatic lane_result_t model_lane(slot_t s);
        lane_result_t r;
        logic [31:0]  ins;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  imm_i;
        logic [31:0]  imm_s;
        logic [31:0]  imm_b;
        logic [31:0]  imm_j;
        logic [2:0]   f3;
        logic         take;
        ins   = s.instruction;
        a     = s.rs1_val;
        b     = s.rs2_val;
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        r = '0;
        if (!s.valid)
            return r;
        r.valid = 1'b1;
        r.rd    = ins[11:7];
        case (ins[6:0])
            7'h33: r.result = alu_ref(f3, ins[30], a, b);
            7'h13: r.result = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
            7'h03:
            begin
                r.result   = a + imm_i;
                r.mem_req  = 1'b1;
                r.mem_addr = a + imm_i;
            end
            7'h23:
            begin
                r.rd         = 5'd0;
                r.mem_req    = 1'b1;
                r.mem_write  = 1'b1;
                r.mem_addr   = a + imm_s;
                r.store_data = b;
            end
            7'h63:
            begin
                r.rd = 5'd0;
                case (f3)
                    3'd0:    take = a == b;
                    3'd1:    take = a != b;
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    3'd7:    take = a >= b;
                    default: take = 1'b0;
                endcase
                r.redirect = take;
                if (take)
                    r.target = s.pc + imm_b;
            end
            7'h6f:
            begin
                r.result   = s.pc + 4;
                r.redirect = 1'b1;
                r.target   = s.pc + imm_j;
            end
            7'h67:
            begin
                r.result   = s.pc + 4;
                r.redirect = 1'b1;
                r.target   = (a + imm_i) & ~32'd1;
            end
            7'h37:   r.result = {ins[31:12], 12'b0};
            default: r.valid = 1'b0;
        endcase
        if (!r.valid)
            return '0;
        r.wb_en = r.rd != 5'd0;
        return r;
    endfunction

    function automatic retire_bundle_t model_retire(lane_result_t [L-1:0] l);
        retire_bundle_t e;
        logic           hit;
        e   = '0;
        hit = 1'b0;
        for (int i = 0; i < L; i++)
        begin
            e.lanes[i] = l[i];
            if (l[i].valid)
                e.strobe = 1'b1;
            if (hit)
            begin
                e.lanes[i].valid   = 1'b0; // behind the redirect
                e.lanes[i].wb_en   = 1'b0;
                e.lanes[i].mem_req = 1'b0;
            end
            else if (l[i].valid && l[i].redirect)
            begin
                hit              = 1'b1;
                e.redirect_valid = 1'b1;
                e.redirect_pc    = l[i].target;
            end
        end
        return e;
    endfunction

    function automatic retire_bundle_t expect_for(slot_t [L-1:0] s);
        lane_result_t [L-1:0] lr;
        for (int i = 0; i < L; i++)
            lr[i] = model_lane(s[i]);
        return model_retire(lr);
    endfunction

    task automatic check_retire(retire_bundle_t e);
        string p;
        check("retire.strobe", 32'(retire.strobe), 32'(e.strobe));
        check("retire.redirect_valid", 32'(retire.redirect_valid), 32'(e.redirect_valid));
        check("retire.redirect_pc", retire.redirect_pc, e.redirect_pc);
        for (int i = 0; i < L; i++)
        begin
            p = $sformatf("retire.lanes[%0d].", i);
            check({p, "valid"}, 32'(retire.lanes[i].valid), 32'(e.lanes[i].valid));
            check({p, "rd"}, 32'(retire.lanes[i].rd), 32'(e.lanes[i].rd));
            check({p, "wb_en"}, 32'(retire.lanes[i].wb_en), 32'(e.lanes[i].wb_en));
            check({p, "result"}, retire.lanes[i].result, e.lanes[i].result);
            check({p, "mem_req"}, 32'(retire.lanes[i].mem_req), 32'(e.lanes[i].mem_req));
            check({p, "mem_write"}, 32'(retire.lanes[i].mem_write),
                  32'(e.lanes[i].mem_write));
            check({p, "mem_addr"}, retire.lanes[i].mem_addr, e.lanes[i].mem_addr);
            check({p, "store_data"}, retire.lanes[i].store_data, e.lanes[i].store_data);
            check({p, "redirect"}, 32'(retire.lanes[i].redirect), 32'(e.lanes[i].redirect));
            check({p, "target"}, retire.lanes[i].target, e.lanes[i].target);
        end
    endtask

    // issue one bundle, retire shows up 3 edges later
    task automatic run_bundle(slot_t [L-1:0] s);
        retire_bundle_t e;
        e = expect_for(s);
        @(posedge clk);
        issue.strobe <= 1'b1;
        issue.slots  <= s;
        @(posedge clk);
        issue <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_retire(e);
    endtask

    task automatic addi_fill(ref slot_t [L-1:0] s, input int from);
        for (int i = from; i < L; i++)
            s[i] = mk({12'($urandom()), 5'd1, 3'd0, 5'd9, 7'h13}, 32'h400 + 32'(4 * i),
                      $urandom(), $urandom());
    endtask

    task automatic alu_test();
        slot_t [L-1:0] s;
        logic [11:0]   imm;
        logic [6:0]    f7;
        logic [2:0]    f3;
        for (int k = 0; k < 10; k++)
        begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            f7  = (k >= 8) ? 7'h20 : 7'h00;
            imm = 12'($urandom());
            imm[11] = k[0] || (k == 2); // negative immediates on odd rounds and slti
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {f7, 5'($urandom())};
            s[0] = mk({f7, 5'd2, 5'd1, f3, 5'd3, 7'h33}, 32'h100, $urandom(), $urandom());
            s[1] = mk({imm, 5'd1, f3, 5'd4, 7'h13}, 32'h104, $urandom(), $urandom());
            s[2] = mk({f7, 5'd2, 5'd1, f3, 5'd0, 7'h33}, 32'h108, $urandom(), $urandom());
            s[3] = mk({imm, 5'd1, f3, 5'd5, 7'h13}, 32'h10c, $urandom() | 32'h8000_0000,
                      $urandom());
            run_bundle(s);
        end
    endtask

    task automatic jump_test();
        slot_t [L-1:0] s;
        addi_fill(s, 0);
        s[0] = mk({20'($urandom()), 5'd6, 7'h37}, 32'h200, $urandom(), $urandom());
        s[3] = mk(enc_j(21'h1ffff0, 5'd1), 32'h20c, $urandom(), $urandom());
        run_bundle(s);
        addi_fill(s, 1);
        s[0] = mk({12'hffd, 5'd2, 3'd0, 5'd1, 7'h67}, 32'h300, 32'h1000_0100, 32'h0);
        run_bundle(s);
        addi_fill(s, 1);
        s[0] = mk(enc_j(21'h000800, 5'd0), 32'h380, $urandom(), $urandom());
        run_bundle(s);
    endtask

    task automatic branch_test();
        slot_t [L-1:0] s;
        logic [2:0]    f3;
        logic [31:0]   a;
        logic [31:0]   b;
        for (int k = 0; k < 6; k++)
        begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int p = 0; p < 3; p++)
            begin
                a = $urandom();
                b = a; // equal pair
                if (p == 1)
                begin
                    a = 32'hffff_fff0;
                    b = 32'd5;
                end
                else if (p == 2)
                begin
                    a = 32'hf000_0000;
                    b = 32'h0000_0010;
                end
                addi_fill(s, 1);
                s[0] = mk(enc_b((p == 1) ? 13'h1ff0 : 13'h0100, 5'd2, 5'd1, f3),
                          32'h800, a, b);
                run_bundle(s);
            end
        end
    endtask

    task automatic mem_test();
        slot_t [L-1:0] s;
        s[0] = mk({12'hffc, 5'd1, 3'd2, 5'd7, 7'h03}, 32'h500, $urandom(), $urandom());
        s[1] = mk({7'h3f, 5'd2, 5'd1, 3'd2, 5'h10, 7'h23}, 32'h504, $urandom(), $urandom());
        s[2] = mk({20'habcde, 5'd8, 7'h17}, 32'h508, $urandom(), $urandom()); // auipc
        s[3] = mk({7'h40, 5'd2, 5'd1, 3'd0, 5'h00, 7'h23}, 32'h50c, $urandom(), $urandom());
        run_bundle(s);
        s[3].valid = 1'b0;
        run_bundle(s);
    endtask

    task automatic squash_test();
        slot_t [L-1:0] s;
        addi_fill(s, 0);
        s[1] = mk(enc_b(13'h0020, 5'd2, 5'd1, 3'd0), 32'h604, 32'h55, 32'h55);
        run_bundle(s);
        check("retire.lanes[2].valid", 32'(retire.lanes[2].valid), 32'd0);
        check("retire.lanes[3].valid", 32'(retire.lanes[3].valid), 32'd0);
        check("retire.redirect_pc", retire.redirect_pc, 32'h624);
        addi_fill(s, 0);
        run_bundle(s);
        for (int i = 0; i < L; i++)
            check($sformatf("retire.lanes[%0d].valid", i), 32'(retire.lanes[i].valid), 32'd1);
        check("retire.redirect_valid", 32'(retire.redirect_valid), 32'd0);
    endtask

    task automatic stream_test();
        slot_t [L-1:0]  s [3];
        slot_t [L-1:0]  t;
        retire_bundle_t e [3];
        for (int n = 0; n < 3; n++)
        begin
            addi_fill(t, 0);
            t[1].valid = (n != 1); // a hole in the middle bundle
            s[n] = t;
            e[n] = expect_for(s[n]);
        end
        for (int n = 0; n < 3; n++)
        begin
            @(posedge clk);
            issue.strobe <= 1'b1;
            issue.slots  <= s[n];
        end
        @(posedge clk);
        issue <= '0;
        for (int n = 0; n < 3; n++)
        begin
            if (n > 0)
                @(posedge clk);
            @(negedge clk);
            check_retire(e[n]);
        end
    endtask

    initial
    begin
        void'($urandom(32'hdce10e42));
        arst_n = 1'b0;
        issue  = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        alu_test();
        jump_test();
        branch_test();
        mem_test();
        squash_test();
        stream_test();
        repeat (2) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- dv/exec_cluster_assert.sv
`include "cluster_macros.svh"

module exec_cluster_assert (
    input logic                        clk,
    input logic                        arst_n,
    input cluster_pkg::issue_bundle_t  issue,
    input cluster_pkg::retire_bundle_t retire
);
    timeunit 1ns;
    timeprecision 1ps;
    import cluster_pkg::*;

    function automatic logic valid_behind_redirect(retire_bundle_t r);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `CLUSTER_LANES; i++)
        begin
            if (seen && r.lanes[i].valid)
                return 1'b1;
            if (r.lanes[i].valid && r.lanes[i].redirect)
                seen = 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic wb_to_x0(retire_bundle_t r);
        for (int i = 0; i < `CLUSTER_LANES; i++)
            if (r.lanes[i].wb_en && r.lanes[i].rd == 5'd0)
                return 1'b1;
        return 1'b0;
    endfunction

    a_strobe_latency: assert property (@(posedge clk) disable iff (!arst_n)
        retire.strobe |-> $past(issue.strobe, 3))
        else $error("retire strobe without an issue strobe 3 cycles before");

    a_squash: assert property (@(posedge clk) disable iff (!arst_n)
        !valid_behind_redirect(retire))
        else $error("valid lane behind a redirecting lane");

    a_wb_rd0: assert property (@(posedge clk) disable iff (!arst_n) !wb_to_x0(retire))
        else $error("wb_en set with rd 0");

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> retire == '0)
        else $error("retire bundle not quiet in reset");

endmodule

bind exec_cluster exec_cluster_assert u_assert (
    .clk    (clk),
    .arst_n (arst_n),
    .issue  (issue),
    .retire (retire)
);

//--- hdl/exec_cluster.sv
`include "cluster_macros.svh"

module exec_cluster (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cluster_pkg::issue_bundle_t  issue,
    output cluster_pkg::retire_bundle_t retire
);
    import cluster_pkg::*;

    slot_t        [`CLUSTER_LANES-1:0] lane_slot;
    lane_result_t [`CLUSTER_LANES-1:0] lane_res;

    issue_stage u_issue (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .lane_slot (lane_slot)
    );

    for (genvar i = 0; i < `CLUSTER_LANES; i++)
    begin : g_lane
        exec_lane u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .slot   (lane_slot[i]),
            .res    (lane_res[i])
        );
    end

    retire_stage u_retire (
        .clk      (clk),
        .arst_n   (arst_n),
        .lane_res (lane_res),
        .retire   (retire)
    );

endmodule

//--- hdl/retire_stage.sv
`include "cluster_macros.svh"

module retire_stage (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  cluster_pkg::lane_result_t [`CLUSTER_LANES-1:0] lane_res,
    output cluster_pkg::retire_bundle_t                   retire
);
    import cluster_pkg::*;

    retire_bundle_t retire_d;
    logic           squash;

    always_comb
    begin
        retire_d = '0;
        squash   = 1'b0;
        for (int i = 0; i < `CLUSTER_LANES; i++)
        begin
            retire_d.lanes[i] = lane_res[i];
            retire_d.strobe   = retire_d.strobe || lane_res[i].valid;
            if (squash)
            begin
                retire_d.lanes[i].valid   = 1'b0; // younger than the redirect
                retire_d.lanes[i].wb_en   = 1'b0;
                retire_d.lanes[i].mem_req = 1'b0;
            end
            else if (lane_res[i].valid && lane_res[i].redirect)
            begin
                retire_d.redirect_valid = 1'b1;
                retire_d.redirect_pc    = lane_res[i].target;
                squash                  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            retire <= '0;
        else
            retire <= retire_d;
    end

endmodule

//--- hdl/issue_stage.sv
`include "cluster_macros.svh"

module issue_stage (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  cluster_pkg::issue_bundle_t             issue,
    output cluster_pkg::slot_t [`CLUSTER_LANES-1:0] lane_slot
);
    import cluster_pkg::*;

    slot_t [`CLUSTER_LANES-1:0] slot_d;

    always_comb
    begin
        for (int i = 0; i < `CLUSTER_LANES; i++)
        begin
            slot_d[i]       = issue.slots[i];
            slot_d[i].valid = issue.strobe && issue.slots[i].valid; // no strobe, no work
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            lane_slot <= '0;
        else
            lane_slot <= slot_d;
    end

endmodule

//--- hdl/exec_lane.sv
`include "cluster_macros.svh"

module exec_lane (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cluster_pkg::slot_t         slot,
    output cluster_pkg::lane_result_t  res
);
    import riscv_isa_pkg::*;
    import cluster_pkg::*;

    decoded_t         dec;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;
    logic             take;
    lane_result_t     res_d;

    control_unit u_dec (
        .instruction (slot.instruction),
        .dec         (dec)
    );

    assign op_b     = dec.alu_source ? dec.imm : slot.rs2_val;
    assign pc_plus4 = slot.pc + `XLEN'd4;

    always_comb
    begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = slot.rs1_val + op_b;
            ALU_SUB:  alu_res = slot.rs1_val - op_b;
            ALU_SLL:  alu_res = slot.rs1_val << op_b[4:0];
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(slot.rs1_val) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, slot.rs1_val < op_b};
            ALU_XOR:  alu_res = slot.rs1_val ^ op_b;
            ALU_SRL:  alu_res = slot.rs1_val >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(slot.rs1_val) >>> op_b[4:0];
            ALU_OR:   alu_res = slot.rs1_val | op_b;
            ALU_AND:  alu_res = slot.rs1_val & op_b;
            default:  alu_res = op_b; // pass b for lui
        endcase
    end

    always_comb
    begin
        case (branch_f3_e'(dec.funct3))
            F3_BEQ:  take = slot.rs1_val == slot.rs2_val;
            F3_BNE:  take = slot.rs1_val != slot.rs2_val;
            F3_BLT:  take = $signed(slot.rs1_val) < $signed(slot.rs2_val);
            F3_BGE:  take = $signed(slot.rs1_val) >= $signed(slot.rs2_val);
            F3_BLTU: take = slot.rs1_val < slot.rs2_val;
            F3_BGEU: take = slot.rs1_val >= slot.rs2_val;
            default: take = 1'b0;
        endcase
    end

    always_comb
    begin
        res_d            = '0;
        res_d.valid      = slot.valid && dec.valid;
        res_d.rd         = dec.rd;
        res_d.wb_en      = dec.reg_write && (dec.rd != 5'd0);
        res_d.result     = dec.load_pc ? pc_plus4 : alu_res;
        res_d.mem_req    = dec.mem_to_reg || dec.mem_write;
        res_d.mem_write  = dec.mem_write;
        res_d.redirect   = dec.load_pc || (dec.branch && take);
        if (res_d.mem_req)
            res_d.mem_addr = alu_res; // rs1 + imm
        if (dec.mem_write)
            res_d.store_data = slot.rs2_val;
        if (!dec.reg_write)
            res_d.result = '0;
        if (dec.opcode == OPC_JALR)
            res_d.target = {alu_res[`XLEN-1:1], 1'b0};
        else if (res_d.redirect)
            res_d.target = slot.pc + dec.imm;
        if (!res_d.valid)
            res_d = '0;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            res <= '0;
        else
            res <= res_d;
    end

endmodule

//--- hdl/control_unit.sv
`include "cluster_macros.svh"

module control_unit (
    input  logic [`XLEN-1:0]      instruction,
    output riscv_isa_pkg::decoded_t dec
);
    import riscv_isa_pkg::*;

    opcode_e          opc;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;
    alu_op_e          f3_op;

    assign opc    = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};

    // funct3 to alu op, alt bit picks sub / sra
    always_comb
    begin
        case (alu_f3_e'(funct3))
            F3_ADD_SUB: f3_op = (opc == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_op = ALU_SLL;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_SRL_SRA: f3_op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_op = ALU_OR;
            default:    f3_op = ALU_AND;
        endcase
    end

    always_comb
    begin
        dec = '0;
        case (opc)
            OPC_OP:
            begin
                dec.rs1       = instruction[19:15];
                dec.rs2       = instruction[24:20];
                dec.rd        = instruction[11:7];
                dec.funct3    = funct3;
                dec.alu_op    = f3_op;
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                dec.rs1        = instruction[19:15];
                dec.rd         = instruction[11:7];
                dec.funct3     = funct3;
                dec.imm        = imm_i;
                dec.alu_op     = f3_op;
                dec.alu_source = 1'b1;
                dec.reg_write  = 1'b1;
            end
            OPC_LOAD:
            begin
                dec.rs1        = instruction[19:15];
                dec.rd         = instruction[11:7];
                dec.funct3     = funct3;
                dec.imm        = imm_i;
                dec.alu_source = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.reg_write  = 1'b1;
            end
            OPC_STORE:
            begin
                dec.rs1        = instruction[19:15];
                dec.rs2        = instruction[24:20];
                dec.funct3     = funct3;
                dec.imm        = imm_s;
                dec.alu_source = 1'b1;
                dec.mem_write  = 1'b1;
            end
            OPC_BRANCH:
            begin
                dec.rs1    = instruction[19:15];
                dec.rs2    = instruction[24:20];
                dec.funct3 = funct3;
                dec.imm    = imm_b;
                dec.branch = 1'b1;
            end
            OPC_JAL:
            begin
                dec.rd        = instruction[11:7];
                dec.imm       = imm_j;
                dec.load_pc   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_JALR:
            begin
                dec.rs1        = instruction[19:15];
                dec.rd         = instruction[11:7];
                dec.funct3     = funct3;
                dec.imm        = imm_i;
                dec.alu_source = 1'b1; // rs1 + imm through the alu
                dec.load_pc    = 1'b1;
                dec.reg_write  = 1'b1;
            end
            OPC_LUI:
            begin
                dec.rd         = instruction[11:7];
                dec.imm        = imm_u;
                dec.alu_op     = ALU_PASS_B;
                dec.alu_source = 1'b1;
                dec.reg_write  = 1'b1;
            end
            default:
            begin
                dec = '0; // unknown opcode
            end
        endcase
        if (dec.reg_write || dec.mem_write || dec.branch)
        begin
            dec.valid  = 1'b1;
            dec.opcode = opc;
        end
    end

endmodule

//--- hdl/cluster_pkg.sv
`include "cluster_macros.svh"

package cluster_pkg;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] instruction;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_val;
        logic [`XLEN-1:0] rs2_val;
    } slot_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic             wb_en;
        logic [`XLEN-1:0] result;
        logic             mem_req;
        logic             mem_write;
        logic [`XLEN-1:0] mem_addr;
        logic [`XLEN-1:0] store_data;
        logic             redirect;
        logic [`XLEN-1:0] target;
    } lane_result_t;

    typedef struct packed {
        logic                              strobe;
        slot_t [`CLUSTER_LANES-1:0]        slots;
    } issue_bundle_t;

    typedef struct packed {
        logic                              strobe;
        lane_result_t [`CLUSTER_LANES-1:0] lanes;
        logic                              redirect_valid;
        logic [`XLEN-1:0]                  redirect_pc; // target of oldest redirecting lane
    } retire_bundle_t;

endpackage

//--- hdl/riscv_isa_pkg.sv
`include "cluster_macros.svh"

package riscv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        opcode_e           opcode;
        logic [2:0]        funct3;
        alu_op_e           alu_op;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  imm;
        logic              alu_source; // 1 selects imm as operand b
        logic              mem_to_reg;
        logic              mem_write;
        logic              branch;
        logic              load_pc;    // jal / jalr
        logic              reg_write;
    } decoded_t;

endpackage

//--- hdl/cluster_macros.svh
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

`define CLUSTER_LANES 4 // execute lanes per bundle
`define XLEN 32         // RV32I data path

`endif
